// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     = --binary --assert --timing
TOP       = switch_endpoint_tb
FILELIST  = files.f
OBJ_DIR   = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== bench/switch_endpoint_assertions.sv ====
`timescale 1ns/1ps

module switch_endpoint_assertions (
    input logic clk,
    input logic arst_n,
    input logic wen,
    input logic error,
    input logic request_stall,
    input logic data_ready_in,
    input logic data_ready_out,
    input logic credit_granted
);

    int   credits;       // free slots left in the neighbour
    logic flit_entered;  // some flit has reached the switch since reset

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            credits      <= switch_cfg_pkg::BUFFER_SIZE;
            flit_entered <= 1'b0;
        end else begin
            if (data_ready_out && !credit_granted) begin
                credits <= credits - 1;
            end else if (credit_granted && !data_ready_out &&
                         credits < switch_cfg_pkg::BUFFER_SIZE) begin
                credits <= credits + 1;
            end
            if ((wen && !error && !request_stall) || data_ready_in) begin
                flit_entered <= 1'b1;  // a clean write can only be a tx push
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // properties
    // ~~~~~~~~~~~~~~~~~~~~

    no_send_without_credit: assert property (@(posedge clk) disable iff (!arst_n)
        data_ready_out |-> credits > 0)
        else $error("flit sent on port 1 with no credit left");

    error_excludes_stall: assert property (@(posedge clk) disable iff (!arst_n)
        !(error && request_stall))
        else $error("error and request_stall high in the same cycle");

    quiet_until_first_flit: assert property (@(posedge clk) disable iff (!arst_n)
        !flit_entered |-> !data_ready_out)
        else $error("data_ready_out high before any flit entered the node");

endmodule

bind switch_endpoint_wrapper switch_endpoint_assertions u_checks (
    .clk           (clk),
    .arst_n        (arst_n),
    .wen           (wen),
    .error         (error),
    .request_stall (request_stall),
    .data_ready_in (data_ready_in),
    .data_ready_out(data_ready_out),
    .credit_granted(credit_granted)
);

// ==== bench/switch_endpoint_tb.sv ====
`timescale 1ns/1ps

module switch_endpoint_tb;

    localparam int TIMEOUT = 400;  // cycles or bus operations per wait

    logic                     clk;
    logic                     arst_n;
    logic                     wen;
    logic                     ren;
    logic [31:0]              addr;
    logic [31:0]              wdata;
    logic [3:0]               strobe;
    logic [31:0]              rdata;
    logic                     error;
    logic                     request_stall;
    chiplet_types_pkg::flit_t in_flit;
    logic                     data_ready_in;
    chiplet_types_pkg::flit_t out_flit;
    logic                     data_ready_out;
    logic                     buffer_available;
    logic                     credit_granted;

    logic [31:0] out_exp [$];  // every word expected on out_flit, in order
    logic [31:0] rx_exp  [$];
    int          out_seen;
    int          credits_req;
    int          credits_sent;
    logic        auto_credit;

    switch_endpoint_wrapper DUT (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // helpers
    // ~~~~~~~~~~~~~~~~~~~~

    task automatic stop_run(input string what);
        $display("Errors found");
        $fatal(1, what);
    endtask

    task automatic expect_equal(input string name, input logic [31:0] exp,
                                input logic [31:0] act);
        assert (act === exp) else begin
            $display("[FAIL] %s expected %h actual %h", name, exp, act);
            stop_run({name, " returned a wrong value"});
        end
    endtask

    // head layout is dest_id, src_id, length, then 24 reserved bits
    function automatic logic [31:0] head_word(input logic [1:0] dest, input logic [1:0] src,
                                              input logic [3:0] len);
        return {dest, src, len, 24'h0};
    endfunction

    // one request on the bus, held while request_stall is high
    task automatic bus_op(input logic write, input logic [31:0] a, input logic [31:0] d,
                          input logic [3:0] s, output logic [31:0] rd, output logic err,
                          output logic stalled);
        int t;
        stalled = 1'b0;
        @(negedge clk);
        wen    = write;
        ren    = !write;
        addr   = a;
        wdata  = d;
        strobe = s;
        for (t = 0; t < TIMEOUT; t++) begin
            @(posedge clk);
            rd  = rdata;
            err = error;
            if (!request_stall) break;
            stalled = 1'b1;
        end
        if (t == TIMEOUT) stop_run("bus write stayed stalled");
        @(negedge clk);
        wen = 1'b0;
        ren = 1'b0;
    endtask

    task automatic write_tx(input logic [31:0] d);
        logic [31:0] rd;
        logic        err;
        logic        st;
        bus_op(1'b1, chiplet_types_pkg::ADDR_TX_DATA, d, 4'hf, rd, err, st);
        expect_equal("tx write error", 32'd0, 32'(err));
        expect_equal("tx write stall", 32'd0, 32'(st));
    endtask

    task automatic send_remote_packet(input logic [1:0] dest, input logic [3:0] len);
        logic [31:0] w;
        for (int i = 0; i <= int'(len); i++) begin
            w = (i == 0) ? head_word(dest, 2'(switch_cfg_pkg::NODE_ID), len) : $urandom;
            out_exp.push_back(w);
            write_tx(w);
        end
    endtask

    task automatic drive_in_flit(input logic [31:0] w);
        int t;
        @(negedge clk);
        for (t = 0; t < TIMEOUT && !buffer_available; t++) @(negedge clk);
        if (!buffer_available) stop_run("port 1 input buffer never had space");
        in_flit.payload = w;
        data_ready_in   = 1'b1;
        @(negedge clk);
        data_ready_in = 1'b0;
    endtask

    task automatic wait_out_seen(input int n, input string what);
        int t;
        for (t = 0; t < TIMEOUT && out_seen < n; t++) @(posedge clk);
        if (out_seen < n) stop_run({"flits missing on out_flit during ", what});
    endtask

    task automatic wait_rx_count(input int n);
        logic [31:0] rd;
        logic        err;
        logic        st;
        int          t;
        rd = '0;
        for (t = 0; t < TIMEOUT && int'(rd[15:8]) < n; t++) begin
            bus_op(1'b0, chiplet_types_pkg::ADDR_STATUS, '0, '0, rd, err, st);
        end
        if (int'(rd[15:8]) < n) stop_run("receive queue never filled");
    endtask

    task automatic grant_credits(input int n);
        int t;
        credits_req = credits_req + n;
        for (t = 0; t < TIMEOUT && credits_sent != credits_req; t++) @(posedge clk);
        if (credits_sent != credits_req) stop_run("credit pulses were not issued");
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // neighbour side
    // ~~~~~~~~~~~~~~~~~~~~

    initial begin
        credit_granted = 1'b0;
        credits_sent   = 0;
        forever begin
            @(negedge clk);
            if (credits_sent < credits_req) begin  // requested pulses go first
                credit_granted = 1'b1;
                credits_sent++;
            end else begin
                credit_granted = auto_credit && ($urandom % 2 == 1);
            end
        end
    end

    always @(posedge clk) begin
        if (arst_n && data_ready_out) begin
            assert (out_seen < out_exp.size()) begin
                expect_equal("out_flit", out_exp[out_seen], out_flit.payload);
                out_seen++;
            end else begin
                stop_run("a flit left on out_flit with none expected");
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // test sequence
    // ~~~~~~~~~~~~~~~~~~~~

    initial begin
        logic [31:0] rd;
        logic [31:0] w;
        logic        err;
        logic        st;
        int          base;
        void'($urandom(32'h2fd9));
        arst_n        = 1'b0;
        wen           = 1'b0;
        ren           = 1'b0;
        addr          = '0;
        wdata         = '0;
        strobe        = '0;
        in_flit       = '0;
        data_ready_in = 1'b0;
        auto_credit   = 1'b0;
        credits_req   = 0;
        out_seen      = 0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        @(negedge clk);
        expect_equal("reset data_ready_out", 32'd0, 32'(data_ready_out));
        expect_equal("reset error", 32'd0, 32'(error));
        expect_equal("reset request_stall", 32'd0, 32'(request_stall));
        expect_equal("reset buffer_available", 32'd1, 32'(buffer_available));
        bus_op(1'b0, chiplet_types_pkg::ADDR_STATUS, '0, '0, rd, err, st);
        expect_equal("reset status", 32'h0001_0000, rd);  // only rx empty set

        bus_op(1'b0, 32'h0000_000c, '0, '0, rd, err, st);
        expect_equal("unmapped read error", 32'd1, 32'(err));
        bus_op(1'b1, chiplet_types_pkg::ADDR_TX_DATA, 32'h1234_5678, 4'b0111, rd, err, st);
        expect_equal("partial strobe error", 32'd1, 32'(err));
        bus_op(1'b1, chiplet_types_pkg::ADDR_STATUS, 32'h1, 4'hf, rd, err, st);
        expect_equal("status write error", 32'd1, 32'(err));
        bus_op(1'b0, chiplet_types_pkg::ADDR_RX_DATA, '0, '0, rd, err, st);
        expect_equal("empty rx read error", 32'd1, 32'(err));

        auto_credit = 1'b1;
        send_remote_packet(2'd2, 4'd3);
        wait_out_seen(out_exp.size(), "outbound packet");

        // a packet for this node ends up in the receive queue
        w = head_word(2'(switch_cfg_pkg::NODE_ID), 2'd2, 4'd2);
        rx_exp.push_back(w);
        drive_in_flit(w);
        for (int i = 0; i < 2; i++) begin
            w = $urandom;
            rx_exp.push_back(w);
            drive_in_flit(w);
        end
        wait_rx_count(3);
        while (rx_exp.size() > 0) begin
            bus_op(1'b0, chiplet_types_pkg::ADDR_RX_DATA, '0, '0, rd, err, st);
            expect_equal("rx read error", 32'd0, 32'(err));
            expect_equal("rx data", rx_exp.pop_front(), rd);
        end

        w = head_word(2'd3, 2'd2, 4'd1);  // passes straight through
        out_exp.push_back(w);
        drive_in_flit(w);
        w = $urandom;
        out_exp.push_back(w);
        drive_in_flit(w);
        wait_out_seen(out_exp.size(), "through traffic");

        auto_credit = 1'b0;
        grant_credits(switch_cfg_pkg::BUFFER_SIZE);  // back to a full budget
        base = out_seen;
        send_remote_packet(2'd2, 4'd11);
        wait_out_seen(base + switch_cfg_pkg::BUFFER_SIZE, "credit limit");
        repeat (20) @(posedge clk);
        expect_equal("flits on full budget", 32'(base + switch_cfg_pkg::BUFFER_SIZE),
                     32'(out_seen));
        grant_credits(4);
        wait_out_seen(base + 12, "credit return");
        repeat (20) @(posedge clk);
        expect_equal("flits after four credits", 32'(base + 12), 32'(out_seen));

        // sixteen flits fill the transmit queue and the switch buffer
        send_remote_packet(2'd2, 4'd15);

        // a refused write to the full queue raises error and no stall
        bus_op(1'b1, chiplet_types_pkg::ADDR_TX_DATA, 32'hdead_beef, 4'b1110, rd, err, st);
        expect_equal("partial strobe error on full queue", 32'd1, 32'(err));
        expect_equal("partial strobe stall on full queue", 32'd0, 32'(st));

        w = head_word(2'd2, 2'(switch_cfg_pkg::NODE_ID), 4'd3);
        out_exp.push_back(w);
        fork
            bus_op(1'b1, chiplet_types_pkg::ADDR_TX_DATA, w, 4'hf, rd, err, st);
            begin
                repeat (10) @(posedge clk);
                grant_credits(switch_cfg_pkg::BUFFER_SIZE);
            end
        join
        expect_equal("request_stall raised", 32'd1, 32'(st));
        for (int i = 0; i < 3; i++) begin
            w = $urandom;
            out_exp.push_back(w);
            write_tx(w);
        end
        auto_credit = 1'b1;
        wait_out_seen(out_exp.size(), "stalled traffic");

        $display("No errors");
        $finish;
    end

endmodule

// ==== design/chiplet_types_pkg.sv ====
package chiplet_types_pkg;

    localparam int FLIT_WIDTH = 32;

    // ~~~~~~~~~~~~~~~~~~~~
    // bus register map
    // ~~~~~~~~~~~~~~~~~~~~

    localparam logic [31:0] ADDR_TX_DATA = 32'h0000_0000;  // write pushes a flit to transmit
    localparam logic [31:0] ADDR_RX_DATA = 32'h0000_0004;  // read pops the receive queue

    // status word layout
    //   [7:0]   transmit queue count
    //   [15:8]  receive queue count
    //   [16]    receive queue empty
    localparam logic [31:0] ADDR_STATUS = 32'h0000_0008;

    // ~~~~~~~~~~~~~~~~~~~~
    // flit word
    // ~~~~~~~~~~~~~~~~~~~~

    // the first flit of a packet is read through the head view and
    // every flit after it is plain payload
    typedef union packed {
        struct packed {
            logic [1:0]  dest_id;
            logic [1:0]  src_id;
            logic [3:0]  length;     // payload flits that follow the head
            logic [23:0] reserved;
        } head;
        logic [FLIT_WIDTH-1:0] payload;
    } flit_t;

endpackage

// ==== design/endpoint.sv ====
`timescale 1ns/1ps

module endpoint (
    input  logic                                          clk,
    input  logic                                          arst_n,
    // processor bus
    input  logic                                          wen,
    input  logic                                          ren,
    input  logic [31:0]                                   addr,
    input  logic [chiplet_types_pkg::FLIT_WIDTH-1:0]      wdata,
    input  logic [chiplet_types_pkg::FLIT_WIDTH/8-1:0]    strobe,
    output logic [chiplet_types_pkg::FLIT_WIDTH-1:0]      rdata,
    output logic                                          error,
    output logic                                          request_stall,
    // switch port 0
    output chiplet_types_pkg::flit_t                      ep_flit,
    output logic                                          ep_valid,
    input  logic                                          ep_ready,
    input  chiplet_types_pkg::flit_t                      sw_flit,
    input  logic                                          sw_valid,
    output logic                                          sw_space
);

    logic sel_tx;
    logic sel_rx;
    logic sel_status;
    logic unmapped;
    logic full_strobe;

    chiplet_types_pkg::flit_t tx_in;
    chiplet_types_pkg::flit_t rx_head;

    logic                                 tx_push;
    logic                                 tx_pop;
    logic                                 tx_empty;
    logic                                 tx_full;
    logic [switch_cfg_pkg::COUNT_WIDTH:0] tx_count;

    logic                                 rx_pop;
    logic                                 rx_empty;
    logic                                 rx_full;
    logic [switch_cfg_pkg::COUNT_WIDTH:0] rx_count;

    // ~~~~~~~~~~~~~~~~~~~~
    // address decode
    // ~~~~~~~~~~~~~~~~~~~~

    assign sel_tx      = (addr == chiplet_types_pkg::ADDR_TX_DATA);
    assign sel_rx      = (addr == chiplet_types_pkg::ADDR_RX_DATA);
    assign sel_status  = (addr == chiplet_types_pkg::ADDR_STATUS);
    assign unmapped    = !(sel_tx || sel_rx || sel_status);
    assign full_strobe = &strobe;  // partial flit writes are refused

    // the bus holds the write while the queue is full
    assign request_stall = wen && sel_tx && full_strobe && tx_full;

    always_comb begin
        error = 1'b0;
        if (wen) begin
            error = unmapped || sel_rx || sel_status || (sel_tx && !full_strobe);
        end else if (ren) begin
            error = unmapped || (sel_rx && rx_empty);
        end
    end

    always_comb begin
        rdata = '0;
        if (ren && sel_rx) begin
            rdata = rx_head.payload;
        end else if (ren && sel_status) begin
            rdata = {15'd0, rx_empty, 8'(rx_count), 8'(tx_count)};
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // transmit queue
    // ~~~~~~~~~~~~~~~~~~~~

    assign tx_in.payload = wdata;
    assign tx_push       = wen && sel_tx && full_strobe && !tx_full;
    assign tx_pop        = ep_valid && ep_ready;
    assign ep_valid      = !tx_empty;  // head of queue goes straight to the switch

    flit_fifo #(
        .DEPTH(switch_cfg_pkg::QUEUE_DEPTH)
    ) tx_queue (
        .clk      (clk),
        .arst_n   (arst_n),
        .push     (tx_push),
        .push_flit(tx_in),
        .pop      (tx_pop),
        .head_flit(ep_flit),
        .empty    (tx_empty),
        .full     (tx_full),
        .count    (tx_count)
    );

    // ~~~~~~~~~~~~~~~~~~~~
    // receive queue
    // ~~~~~~~~~~~~~~~~~~~~

    assign sw_space = !rx_full;                  // switch only sends while this is high
    assign rx_pop   = ren && sel_rx && !rx_empty;

    flit_fifo #(
        .DEPTH(switch_cfg_pkg::QUEUE_DEPTH)
    ) rx_queue (
        .clk      (clk),
        .arst_n   (arst_n),
        .push     (sw_valid),
        .push_flit(sw_flit),
        .pop      (rx_pop),
        .head_flit(rx_head),
        .empty    (rx_empty),
        .full     (rx_full),
        .count    (rx_count)
    );

endmodule

// ==== design/flit_fifo.sv ====
`timescale 1ns/1ps

module flit_fifo #(
    parameter int DEPTH = 8
) (
    input  logic                                 clk,
    input  logic                                 arst_n,
    input  logic                                 push,
    input  chiplet_types_pkg::flit_t             push_flit,
    input  logic                                 pop,
    output chiplet_types_pkg::flit_t             head_flit,
    output logic                                 empty,
    output logic                                 full,
    output logic [switch_cfg_pkg::COUNT_WIDTH:0] count
);

    chiplet_types_pkg::flit_t mem [DEPTH];

    logic [$clog2(DEPTH)-1:0] rd_ptr;
    logic [$clog2(DEPTH)-1:0] wr_ptr;
    logic                     do_push;
    logic                     do_pop;

    assign empty = (count == '0);
    assign full  = (count == (switch_cfg_pkg::COUNT_WIDTH + 1)'(DEPTH));

    assign do_pop  = pop && !empty;
    assign do_push = push && (!full || do_pop);  // a pop in the same cycle frees the slot

    assign head_flit = mem[rd_ptr];  // visible one cycle after the push

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == ($clog2(DEPTH))'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == ($clog2(DEPTH))'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // storage
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_flit;
        end
    end

endmodule

// ==== design/switch.sv ====
`timescale 1ns/1ps

module switch (
    input  logic                     clk,
    input  logic                     arst_n,
    // port 0, local endpoint
    input  chiplet_types_pkg::flit_t ep_flit,
    input  logic                     ep_valid,
    output logic                     ep_ready,
    output chiplet_types_pkg::flit_t sw_flit,
    output logic                     sw_valid,
    input  logic                     sw_space,
    // port 1, neighbouring chiplet
    input  chiplet_types_pkg::flit_t in_flit,
    input  logic                     data_ready_in,
    output logic                     buffer_available,
    output chiplet_types_pkg::flit_t out_flit,
    output logic                     data_ready_out,
    input  logic                     credit_granted
);

    chiplet_types_pkg::flit_t in_data [switch_cfg_pkg::NUM_PORTS];
    chiplet_types_pkg::flit_t in_head [switch_cfg_pkg::NUM_PORTS];

    logic [switch_cfg_pkg::NUM_PORTS-1:0] in_push;
    logic [switch_cfg_pkg::NUM_PORTS-1:0] in_pop;
    logic [switch_cfg_pkg::NUM_PORTS-1:0] in_empty;
    logic [switch_cfg_pkg::COUNT_WIDTH:0] in_count [switch_cfg_pkg::NUM_PORTS];

    // per input route state
    logic                                         in_locked [switch_cfg_pkg::NUM_PORTS];
    logic [$clog2(switch_cfg_pkg::NUM_PORTS)-1:0] in_route  [switch_cfg_pkg::NUM_PORTS];
    logic [$clog2(switch_cfg_pkg::NUM_PORTS)-1:0] in_target [switch_cfg_pkg::NUM_PORTS];
    logic [3:0]                                   in_remain [switch_cfg_pkg::NUM_PORTS];

    // per output arbitration
    logic [switch_cfg_pkg::NUM_PORTS-1:0]         out_ready;
    logic [switch_cfg_pkg::NUM_PORTS-1:0]         out_grant;
    logic [switch_cfg_pkg::NUM_PORTS-1:0]         out_fire;
    logic [$clog2(switch_cfg_pkg::NUM_PORTS)-1:0] grant_idx [switch_cfg_pkg::NUM_PORTS];
    logic [$clog2(switch_cfg_pkg::NUM_PORTS)-1:0] rr_last   [switch_cfg_pkg::NUM_PORTS];

    logic [switch_cfg_pkg::COUNT_WIDTH-1:0] credit_count;  // free slots in the neighbour

    assign in_data[0] = ep_flit;
    assign in_push[0] = ep_valid && ep_ready;
    assign in_data[1] = in_flit;
    assign in_push[1] = data_ready_in;  // sender honours buffer_available

    assign ep_ready         = in_count[0] < (switch_cfg_pkg::COUNT_WIDTH + 1)'(switch_cfg_pkg::BUFFER_SIZE);
    assign buffer_available = in_count[1] < (switch_cfg_pkg::COUNT_WIDTH + 1)'(switch_cfg_pkg::BUFFER_SIZE);

    // ~~~~~~~~~~~~~~~~~~~~
    // input buffers and routing
    // ~~~~~~~~~~~~~~~~~~~~

    for (genvar p = 0; p < switch_cfg_pkg::NUM_PORTS; p++) begin : g_in
        flit_fifo #(
            .DEPTH(switch_cfg_pkg::BUFFER_SIZE)
        ) in_buf (
            .clk      (clk),
            .arst_n   (arst_n),
            .push     (in_push[p]),
            .push_flit(in_data[p]),
            .pop      (in_pop[p]),
            .head_flit(in_head[p]),
            .empty    (in_empty[p]),
            .full     (),
            .count    (in_count[p])
        );

        // anything not addressed to this node leaves on port 1
        assign in_target[p] = in_locked[p] ? in_route[p] :
            ($clog2(switch_cfg_pkg::NUM_PORTS))'(in_head[p].head.dest_id != 2'(switch_cfg_pkg::NODE_ID));

        always_ff @(posedge clk or negedge arst_n) begin
            if (!arst_n) begin
                in_locked[p] <= 1'b0;
                in_route[p]  <= '0;
                in_remain[p] <= '0;
            end else if (in_pop[p]) begin
                if (!in_locked[p]) begin  // head flit leaving
                    in_locked[p] <= (in_head[p].head.length != '0);
                    in_route[p]  <= in_target[p];
                    in_remain[p] <= in_head[p].head.length;
                end else begin
                    in_remain[p] <= in_remain[p] - 1'b1;
                    if (in_remain[p] == 4'd1) begin
                        in_locked[p] <= 1'b0;
                    end
                end
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // output arbitration
    // ~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        logic held;
        int   cand;
        held = 1'b0;
        cand = 0;
        for (int o = 0; o < switch_cfg_pkg::NUM_PORTS; o++) begin
            out_grant[o] = 1'b0;
            grant_idx[o] = '0;
            held         = 1'b0;
            // an open packet keeps its output until the tail
            for (int i = 0; i < switch_cfg_pkg::NUM_PORTS; i++) begin
                if (in_locked[i] && int'(in_route[i]) == o) begin
                    held         = 1'b1;
                    grant_idx[o] = ($clog2(switch_cfg_pkg::NUM_PORTS))'(i);
                    out_grant[o] = !in_empty[i];
                end
            end
            if (!held) begin
                for (int k = 1; k <= switch_cfg_pkg::NUM_PORTS; k++) begin
                    cand = (int'(rr_last[o]) + k) % switch_cfg_pkg::NUM_PORTS;
                    if (!out_grant[o] && !in_empty[cand] && int'(in_target[cand]) == o) begin
                        out_grant[o] = 1'b1;
                        grant_idx[o] = ($clog2(switch_cfg_pkg::NUM_PORTS))'(cand);
                    end
                end
            end
        end
    end

    assign out_ready[0] = sw_space;
    assign out_ready[1] = (credit_count != '0);
    assign out_fire     = out_grant & out_ready;

    always_comb begin
        in_pop = '0;
        for (int o = 0; o < switch_cfg_pkg::NUM_PORTS; o++) begin
            if (out_fire[o]) begin
                in_pop[grant_idx[o]] = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int o = 0; o < switch_cfg_pkg::NUM_PORTS; o++) begin
                rr_last[o] <= '0;
            end
        end else begin
            for (int o = 0; o < switch_cfg_pkg::NUM_PORTS; o++) begin
                if (out_fire[o]) begin
                    rr_last[o] <= grant_idx[o];
                end
            end
        end
    end

    // credits saturate at the neighbour's buffer size
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            credit_count <= (switch_cfg_pkg::COUNT_WIDTH)'(switch_cfg_pkg::BUFFER_SIZE);
        end else if (credit_granted && !out_fire[1]) begin
            if (credit_count < (switch_cfg_pkg::COUNT_WIDTH)'(switch_cfg_pkg::BUFFER_SIZE)) begin
                credit_count <= credit_count + 1'b1;
            end
        end else if (!credit_granted && out_fire[1]) begin
            credit_count <= credit_count - 1'b1;
        end
    end

    assign sw_valid       = out_fire[0];
    assign sw_flit        = in_head[grant_idx[0]];
    assign data_ready_out = out_fire[1];
    assign out_flit       = in_head[grant_idx[1]];

endmodule

// ==== design/switch_cfg_pkg.sv ====
package switch_cfg_pkg;

    // id of this node on the chiplet network
    localparam int NODE_ID = 1;

    // port 0 is the local endpoint, port 1 goes to the neighbour
    localparam int NUM_PORTS = 2;

    // ~~~~~~~~~~~~~~~~~~~~
    // buffering
    // ~~~~~~~~~~~~~~~~~~~~

    localparam int BUFFER_SIZE = 8;  // switch input depth and the neighbour's starting credits
    localparam int QUEUE_DEPTH = 8;  // endpoint transmit and receive queues

    // fifo counts carry one extra bit on top of this
    localparam int COUNT_WIDTH = 4;

endpackage

// ==== design/switch_endpoint_wrapper.sv ====
`timescale 1ns/1ps

module switch_endpoint_wrapper (
    input  logic                                       clk,
    input  logic                                       arst_n,
    // processor bus
    input  logic                                       wen,
    input  logic                                       ren,
    input  logic [31:0]                                addr,
    input  logic [chiplet_types_pkg::FLIT_WIDTH-1:0]   wdata,
    input  logic [chiplet_types_pkg::FLIT_WIDTH/8-1:0] strobe,
    output logic [chiplet_types_pkg::FLIT_WIDTH-1:0]   rdata,
    output logic                                       error,
    output logic                                       request_stall,
    // neighbouring chiplet on switch port 1
    input  chiplet_types_pkg::flit_t                   in_flit,
    input  logic                                       data_ready_in,
    output chiplet_types_pkg::flit_t                   out_flit,
    output logic                                       data_ready_out,
    output logic                                       buffer_available,
    input  logic                                       credit_granted
);

    // endpoint to switch port 0
    chiplet_types_pkg::flit_t ep_flit;
    logic                     ep_valid;
    logic                     ep_ready;
    chiplet_types_pkg::flit_t sw_flit;
    logic                     sw_valid;
    logic                     sw_space;

    endpoint endpoint1 (
        .clk          (clk),
        .arst_n       (arst_n),
        .wen          (wen),
        .ren          (ren),
        .addr         (addr),
        .wdata        (wdata),
        .strobe       (strobe),
        .rdata        (rdata),
        .error        (error),
        .request_stall(request_stall),
        .ep_flit      (ep_flit),
        .ep_valid     (ep_valid),
        .ep_ready     (ep_ready),
        .sw_flit      (sw_flit),
        .sw_valid     (sw_valid),
        .sw_space     (sw_space)
    );

    switch switch1 (
        .clk             (clk),
        .arst_n          (arst_n),
        .ep_flit         (ep_flit),
        .ep_valid        (ep_valid),
        .ep_ready        (ep_ready),
        .sw_flit         (sw_flit),
        .sw_valid        (sw_valid),
        .sw_space        (sw_space),
        .in_flit         (in_flit),
        .data_ready_in   (data_ready_in),
        .buffer_available(buffer_available),
        .out_flit        (out_flit),
        .data_ready_out  (data_ready_out),
        .credit_granted  (credit_granted)
    );

endmodule

// ==== files.f ====
design/chiplet_types_pkg.sv
design/switch_cfg_pkg.sv
design/flit_fifo.sv
design/switch.sv
design/endpoint.sv
design/switch_endpoint_wrapper.sv
bench/switch_endpoint_assertions.sv
bench/switch_endpoint_tb.sv
